// File: verilog/lce_cfg_pkg.sv
// geometry constants and plain vector typedefs for the icache coherence engine
`default_nettype none

package lce_cfg_pkg;

  // physical address holds tag, index and block offset from the top down
  localparam int paddr_width_c        = 40;
  localparam int block_offset_width_c = 6;
  localparam int index_width_c        = 6;
  localparam int ptag_width_c         = paddr_width_c - index_width_c - block_offset_width_c;

  // 8 ways per set
  localparam int way_width_c = 3;

  // directory and engine ids share one width
  localparam int id_width_c = 3;

  // fill data carried by one command
  localparam int block_width_c = 64;

  typedef logic [paddr_width_c-1:0] paddr_t;

  typedef logic [index_width_c-1:0] index_t;

  typedef logic [ptag_width_c-1:0] ptag_t;

  typedef logic [way_width_c-1:0] way_t;

  typedef logic [id_width_c-1:0] node_id_t;

  typedef logic [block_width_c-1:0] block_t;

endpackage

`default_nettype wire

// File: verilog/lce_msg_pkg.sv
// command, response and memory packet enums and packed structs
`default_nettype none

package lce_msg_pkg;
  import lce_cfg_pkg::*;

  // commands sent by a directory
  typedef enum logic [3:0] {
    e_cmd_set_clear      = 4'h0,
    e_cmd_sync           = 4'h1,
    e_cmd_uc_data        = 4'h2,
    e_cmd_set_tag        = 4'h3,
    e_cmd_set_tag_wakeup = 4'h4,
    e_cmd_invalidate_tag = 4'h5,
    e_cmd_data           = 4'h6,
    e_cmd_writeback      = 4'h7
  } lce_cmd_type_e;

  typedef enum logic [1:0] {
    e_resp_sync_ack = 2'h0,
    e_resp_inv_ack  = 2'h1,
    e_resp_null_wb  = 2'h2
  } lce_resp_type_e;

  typedef enum logic [2:0] {
    e_coh_i = 3'h0,
    e_coh_s = 3'h1,
    e_coh_e = 3'h2,
    e_coh_m = 3'h3
  } coh_state_e;

  typedef enum logic [1:0] {
    e_tag_set_clear  = 2'h0,
    e_tag_set_tag    = 2'h1,
    e_tag_invalidate = 2'h2
  } tag_op_e;

  typedef enum logic [0:0] {
    e_data_write    = 1'b0,
    e_data_uncached = 1'b1
  } data_op_e;

  typedef struct packed {
    lce_cmd_type_e msg_type;
    node_id_t      src_id;
    way_t          way_id;
    coh_state_e    state;
    paddr_t        addr;
    block_t        data;
  } lce_cmd_s;

  typedef struct packed {
    lce_resp_type_e msg_type;
    node_id_t       src_id;
    node_id_t       dst_id;
    paddr_t         addr;
  } lce_resp_s;

  typedef struct packed {
    tag_op_e    opcode;
    index_t     index;
    way_t       way_id;
    coh_state_e state;
    ptag_t      tag;
  } tag_pkt_s;

  typedef struct packed {
    index_t index;
    logic   clear;
  } stat_pkt_s;

  typedef struct packed {
    data_op_e opcode;
    index_t   index;
    way_t     way_id;
    block_t   data;
  } data_pkt_s;

  // engine operating mode
  typedef enum logic [1:0] {
    e_mode_reset         = 2'h0,
    e_mode_uncached_only = 2'h1,
    e_mode_ready         = 2'h2
  } lce_mode_e;

endpackage

`default_nettype wire

// File: verilog/lce_init_sweep.sv
// post-reset set counter that offers tag and status clear packets
`timescale 1ns/10ps
`default_nettype none

module lce_init_sweep
  import lce_cfg_pkg::*;
  import lce_msg_pkg::*;
#(
  parameter int num_sets_p = 64
) (
  input  wire logic clk_i,
  input  wire logic reset_i,
  input  wire logic step_ready_i,
  output tag_pkt_s  tag_pkt_o,
  output stat_pkt_s stat_pkt_o,
  output logic      pkt_v_o,
  output logic      done_o
);

  index_t set_r;
  logic   last_set;

  assign last_set = (set_r == index_t'(num_sets_p - 1));

  // clear packets for the current set
  always_comb begin
    tag_pkt_o        = '0;
    tag_pkt_o.opcode = e_tag_set_clear;
    tag_pkt_o.index  = set_r;
    tag_pkt_o.state  = e_coh_i;

    stat_pkt_o       = '0;
    stat_pkt_o.index = set_r;
    stat_pkt_o.clear = 1'b1;
  end

  // a step is one cycle with both memories ready
  assign pkt_v_o = step_ready_i;
  assign done_o  = step_ready_i & last_set;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      set_r <= '0;
    end else if (step_ready_i) begin
      set_r <= set_r + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/lce_cmd_decode.sv
// command decoder building memory packets, responses and event strobes
`timescale 1ns/10ps
`default_nettype none

module lce_cmd_decode
  import lce_cfg_pkg::*;
  import lce_msg_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      reset_i,
  input  wire lce_mode_e mode_i,
  input  wire node_id_t  lce_id_i,
  input  wire paddr_t    miss_addr_i,
  input  wire lce_cmd_s  lce_cmd_i,
  input  wire logic      lce_cmd_v_i,
  input  wire logic      lce_resp_yumi_i,
  input  wire logic      tag_pkt_ready_i,
  input  wire logic      stat_pkt_ready_i,
  input  wire logic      data_pkt_ready_i,
  output logic           lce_cmd_yumi_o,
  output lce_resp_s      lce_resp_o,
  output logic           lce_resp_v_o,
  output tag_pkt_s       tag_pkt_o,
  output logic           tag_pkt_v_o,
  output stat_pkt_s      stat_pkt_o,
  output logic           stat_pkt_v_o,
  output data_pkt_s      data_pkt_o,
  output logic           data_pkt_v_o,
  output logic           sync_ack_o,
  output logic           set_tag_received_o,
  output logic           set_tag_wakeup_received_o,
  output logic           cce_data_received_o,
  output logic           uncached_data_received_o,
  output logic           cache_req_complete_o
);

  index_t cmd_index;
  ptag_t  cmd_tag;
  index_t miss_index;
  logic   uc_ok;
  logic   rdy_ok;
  logic   inv_r;
  logic   inv_n;

  assign cmd_index  = lce_cmd_i.addr[block_offset_width_c +: index_width_c];
  assign cmd_tag    = lce_cmd_i.addr[block_offset_width_c + index_width_c +: ptag_width_c];
  assign miss_index = miss_addr_i[block_offset_width_c +: index_width_c];

  // uncached commands work in both later modes, the rest only once ready
  assign uc_ok  = lce_cmd_v_i & (mode_i != e_mode_reset);
  assign rdy_ok = lce_cmd_v_i & (mode_i == e_mode_ready);

  always_comb begin
    lce_cmd_yumi_o            = 1'b0;
    lce_resp_o                = '0;
    lce_resp_o.src_id         = lce_id_i;
    lce_resp_o.dst_id         = lce_cmd_i.src_id;
    lce_resp_o.addr           = lce_cmd_i.addr;
    lce_resp_v_o              = 1'b0;
    tag_pkt_o                 = '0;
    tag_pkt_o.way_id          = lce_cmd_i.way_id;
    tag_pkt_v_o               = 1'b0;
    stat_pkt_o                = '0;
    stat_pkt_v_o              = 1'b0;
    data_pkt_o                = '0;
    data_pkt_o.index          = miss_index;
    data_pkt_o.way_id         = lce_cmd_i.way_id;
    data_pkt_o.data           = lce_cmd_i.data;
    data_pkt_v_o              = 1'b0;
    sync_ack_o                = 1'b0;
    set_tag_received_o        = 1'b0;
    set_tag_wakeup_received_o = 1'b0;
    cce_data_received_o       = 1'b0;
    uncached_data_received_o  = 1'b0;
    cache_req_complete_o      = 1'b0;
    inv_n                     = inv_r;

    case (lce_cmd_i.msg_type)
      e_cmd_set_clear: begin
        tag_pkt_o.opcode = e_tag_set_clear;
        tag_pkt_o.index  = cmd_index;
        tag_pkt_o.state  = e_coh_i;
        stat_pkt_o.index = cmd_index;
        stat_pkt_o.clear = 1'b1;
        tag_pkt_v_o      = uc_ok & tag_pkt_ready_i & stat_pkt_ready_i;
        stat_pkt_v_o     = tag_pkt_v_o;
        lce_cmd_yumi_o   = tag_pkt_v_o;
      end
      e_cmd_sync: begin
        lce_resp_o.msg_type = e_resp_sync_ack;
        lce_resp_v_o        = uc_ok;
        lce_cmd_yumi_o      = uc_ok & lce_resp_yumi_i;
        sync_ack_o          = lce_cmd_yumi_o;
      end
      e_cmd_uc_data: begin
        data_pkt_o.opcode        = e_data_uncached;
        data_pkt_v_o             = uc_ok & data_pkt_ready_i;
        lce_cmd_yumi_o           = data_pkt_v_o;
        uncached_data_received_o = data_pkt_v_o;
        cache_req_complete_o     = data_pkt_v_o;
      end
      e_cmd_set_tag, e_cmd_set_tag_wakeup: begin
        tag_pkt_o.opcode = e_tag_set_tag;
        tag_pkt_o.index  = cmd_index;
        tag_pkt_o.state  = lce_cmd_i.state;
        tag_pkt_o.tag    = cmd_tag;
        tag_pkt_v_o      = rdy_ok & tag_pkt_ready_i;
        lce_cmd_yumi_o   = tag_pkt_v_o;
        if (lce_cmd_i.msg_type == e_cmd_set_tag) begin
          set_tag_received_o = tag_pkt_v_o;
        end else begin
          set_tag_wakeup_received_o = tag_pkt_v_o;
          cache_req_complete_o      = tag_pkt_v_o;
        end
      end
      e_cmd_invalidate_tag: begin
        tag_pkt_o.opcode = e_tag_invalidate;
        tag_pkt_o.index  = cmd_index;
        tag_pkt_o.state  = e_coh_i;
        // tag is written once, the flag then holds the ack
        tag_pkt_v_o         = rdy_ok & tag_pkt_ready_i & ~inv_r;
        lce_resp_o.msg_type = e_resp_inv_ack;
        lce_resp_v_o        = inv_r | tag_pkt_v_o;
        lce_cmd_yumi_o      = lce_resp_v_o & lce_resp_yumi_i;
        inv_n               = lce_resp_v_o & ~lce_resp_yumi_i;
      end
      e_cmd_data: begin
        data_pkt_o.opcode    = e_data_write;
        tag_pkt_o.opcode     = e_tag_set_tag;
        tag_pkt_o.index      = miss_index;
        tag_pkt_o.state      = lce_cmd_i.state;
        tag_pkt_o.tag        = cmd_tag;
        tag_pkt_v_o          = rdy_ok & tag_pkt_ready_i & data_pkt_ready_i;
        data_pkt_v_o         = tag_pkt_v_o;
        lce_cmd_yumi_o       = tag_pkt_v_o;
        cce_data_received_o  = tag_pkt_v_o;
        set_tag_received_o   = tag_pkt_v_o;
        cache_req_complete_o = tag_pkt_v_o;
      end
      e_cmd_writeback: begin
        lce_resp_o.msg_type = e_resp_null_wb;
        lce_resp_v_o        = rdy_ok;
        lce_cmd_yumi_o      = rdy_ok & lce_resp_yumi_i;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      inv_r <= 1'b0;
    end else begin
      inv_r <= inv_n;
    end
  end

endmodule

`default_nettype wire

// File: verilog/lce_mode_ctrl.sv
// mode state machine, sync counter and tag/status packet source select
`timescale 1ns/10ps
`default_nettype none

module lce_mode_ctrl
  import lce_msg_pkg::*;
#(
  parameter int num_cce_p = 2
) (
  input  wire logic      clk_i,
  input  wire logic      reset_i,
  input  wire logic      sweep_done_i,
  input  wire logic      sync_ack_i,
  input  wire tag_pkt_s  sweep_tag_pkt_i,
  input  wire stat_pkt_s sweep_stat_pkt_i,
  input  wire logic      sweep_pkt_v_i,
  input  wire tag_pkt_s  dec_tag_pkt_i,
  input  wire logic      dec_tag_pkt_v_i,
  input  wire stat_pkt_s dec_stat_pkt_i,
  input  wire logic      dec_stat_pkt_v_i,
  input  wire logic      tag_pkt_ready_i,
  input  wire logic      stat_pkt_ready_i,
  output lce_mode_e      mode_o,
  output logic           sweep_step_o,
  output tag_pkt_s       tag_pkt_o,
  output logic           tag_pkt_v_o,
  output stat_pkt_s      stat_pkt_o,
  output logic           stat_pkt_v_o,
  output logic           lce_ready_o
);

  localparam int cnt_width_lp = (num_cce_p > 1) ? $clog2(num_cce_p) : 1;

  lce_mode_e               mode_r;
  lce_mode_e               mode_n;
  logic [cnt_width_lp-1:0] sync_cnt_r;
  logic [cnt_width_lp-1:0] sync_cnt_n;
  logic                    in_sweep;
  logic                    last_sync;

  assign in_sweep  = (mode_r == e_mode_reset);
  assign last_sync = (sync_cnt_r == cnt_width_lp'(num_cce_p - 1));

  // the sweep owns both memories until it is done
  assign sweep_step_o = in_sweep & tag_pkt_ready_i & stat_pkt_ready_i;

  assign tag_pkt_o    = in_sweep ? sweep_tag_pkt_i : dec_tag_pkt_i;
  assign tag_pkt_v_o  = in_sweep ? sweep_pkt_v_i : dec_tag_pkt_v_i;
  assign stat_pkt_o   = in_sweep ? sweep_stat_pkt_i : dec_stat_pkt_i;
  assign stat_pkt_v_o = in_sweep ? sweep_pkt_v_i : dec_stat_pkt_v_i;

  assign mode_o      = mode_r;
  assign lce_ready_o = ~in_sweep;

  always_comb begin
    mode_n     = mode_r;
    sync_cnt_n = sync_cnt_r;
    case (mode_r)
      e_mode_reset: begin
        if (sweep_done_i) begin
          mode_n = e_mode_uncached_only;
        end
      end
      e_mode_uncached_only: begin
        // one sync ack per directory
        if (sync_ack_i) begin
          if (last_sync) begin
            mode_n     = e_mode_ready;
            sync_cnt_n = '0;
          end else begin
            sync_cnt_n = sync_cnt_r + 1'b1;
          end
        end
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mode_r     <= e_mode_reset;
      sync_cnt_r <= '0;
    end else begin
      mode_r     <= mode_n;
      sync_cnt_r <= sync_cnt_n;
    end
  end

endmodule

`default_nettype wire

// File: verilog/icache_lce_cmd.sv
// icache coherence engine command side top level
`timescale 1ns/10ps
`default_nettype none

module icache_lce_cmd
  import lce_cfg_pkg::*;
  import lce_msg_pkg::*;
#(
  parameter int num_sets_p = 64,
  parameter int num_cce_p  = 2
) (
  input  wire logic     clk_i,
  input  wire logic     reset_i,
  input  wire node_id_t lce_id_i,
  input  wire paddr_t   miss_addr_i,
  input  wire lce_cmd_s lce_cmd_i,
  input  wire logic     lce_cmd_v_i,
  output logic          lce_cmd_yumi_o,
  output lce_resp_s     lce_resp_o,
  output logic          lce_resp_v_o,
  input  wire logic     lce_resp_yumi_i,
  output tag_pkt_s      tag_pkt_o,
  output logic          tag_pkt_v_o,
  input  wire logic     tag_pkt_ready_i,
  output stat_pkt_s     stat_pkt_o,
  output logic          stat_pkt_v_o,
  input  wire logic     stat_pkt_ready_i,
  output data_pkt_s     data_pkt_o,
  output logic          data_pkt_v_o,
  input  wire logic     data_pkt_ready_i,
  output logic          lce_ready_o,
  output logic          set_tag_received_o,
  output logic          set_tag_wakeup_received_o,
  output logic          cce_data_received_o,
  output logic          uncached_data_received_o,
  output logic          cache_req_complete_o
);

  lce_mode_e mode;
  logic      sweep_step;
  logic      sweep_done;
  logic      sweep_pkt_v;
  tag_pkt_s  sweep_tag_pkt;
  stat_pkt_s sweep_stat_pkt;
  tag_pkt_s  dec_tag_pkt;
  logic      dec_tag_pkt_v;
  stat_pkt_s dec_stat_pkt;
  logic      dec_stat_pkt_v;
  logic      sync_ack;

  lce_init_sweep #(
    .num_sets_p(num_sets_p)
  ) sweep0 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .step_ready_i(sweep_step),
    .tag_pkt_o   (sweep_tag_pkt),
    .stat_pkt_o  (sweep_stat_pkt),
    .pkt_v_o     (sweep_pkt_v),
    .done_o      (sweep_done)
  );

  lce_cmd_decode decode0 (
    .clk_i                    (clk_i),
    .reset_i                  (reset_i),
    .mode_i                   (mode),
    .lce_id_i                 (lce_id_i),
    .miss_addr_i              (miss_addr_i),
    .lce_cmd_i                (lce_cmd_i),
    .lce_cmd_v_i              (lce_cmd_v_i),
    .lce_resp_yumi_i          (lce_resp_yumi_i),
    .tag_pkt_ready_i          (tag_pkt_ready_i),
    .stat_pkt_ready_i         (stat_pkt_ready_i),
    .data_pkt_ready_i         (data_pkt_ready_i),
    .lce_cmd_yumi_o           (lce_cmd_yumi_o),
    .lce_resp_o               (lce_resp_o),
    .lce_resp_v_o             (lce_resp_v_o),
    .tag_pkt_o                (dec_tag_pkt),
    .tag_pkt_v_o              (dec_tag_pkt_v),
    .stat_pkt_o               (dec_stat_pkt),
    .stat_pkt_v_o             (dec_stat_pkt_v),
    .data_pkt_o               (data_pkt_o),
    .data_pkt_v_o             (data_pkt_v_o),
    .sync_ack_o               (sync_ack),
    .set_tag_received_o       (set_tag_received_o),
    .set_tag_wakeup_received_o(set_tag_wakeup_received_o),
    .cce_data_received_o      (cce_data_received_o),
    .uncached_data_received_o (uncached_data_received_o),
    .cache_req_complete_o     (cache_req_complete_o)
  );

  lce_mode_ctrl #(
    .num_cce_p(num_cce_p)
  ) mode0 (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .sweep_done_i    (sweep_done),
    .sync_ack_i      (sync_ack),
    .sweep_tag_pkt_i (sweep_tag_pkt),
    .sweep_stat_pkt_i(sweep_stat_pkt),
    .sweep_pkt_v_i   (sweep_pkt_v),
    .dec_tag_pkt_i   (dec_tag_pkt),
    .dec_tag_pkt_v_i (dec_tag_pkt_v),
    .dec_stat_pkt_i  (dec_stat_pkt),
    .dec_stat_pkt_v_i(dec_stat_pkt_v),
    .tag_pkt_ready_i (tag_pkt_ready_i),
    .stat_pkt_ready_i(stat_pkt_ready_i),
    .mode_o          (mode),
    .sweep_step_o    (sweep_step),
    .tag_pkt_o       (tag_pkt_o),
    .tag_pkt_v_o     (tag_pkt_v_o),
    .stat_pkt_o      (stat_pkt_o),
    .stat_pkt_v_o    (stat_pkt_v_o),
    .lce_ready_o     (lce_ready_o)
  );

endmodule

`default_nettype wire

// File: verification/icache_lce_cmd_asserts.sv
// handshake assertions for the command, response and memory packet channels
`timescale 1ns/10ps
`default_nettype none

module icache_lce_cmd_asserts (
  input wire logic clk_i,
  input wire logic reset_i,
  input wire logic lce_cmd_v_i,
  input wire logic lce_cmd_yumi_o,
  input wire logic lce_resp_v_o,
  input wire logic lce_resp_yumi_i,
  input wire logic tag_pkt_v_o,
  input wire logic tag_pkt_ready_i,
  input wire logic stat_pkt_v_o,
  input wire logic stat_pkt_ready_i,
  input wire logic data_pkt_v_o,
  input wire logic data_pkt_ready_i
);

  cmd_yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    lce_cmd_yumi_o |-> lce_cmd_v_i)
    else $error("command yumi raised without command valid");

  // a packet counts as written in the cycle its valid is up
  tag_valid_needs_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    tag_pkt_v_o |-> tag_pkt_ready_i)
    else $error("tag packet valid while tag memory not ready");

  stat_valid_needs_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    stat_pkt_v_o |-> stat_pkt_ready_i)
    else $error("status packet valid while status memory not ready");

  data_valid_needs_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    data_pkt_v_o |-> data_pkt_ready_i)
    else $error("data packet valid while data memory not ready");

  resp_held_until_yumi: assert property (@(posedge clk_i) disable iff (reset_i)
    (lce_resp_v_o && !lce_resp_yumi_i) |=> lce_resp_v_o)
    else $error("response valid dropped before its yumi");

endmodule

`default_nettype wire

// File: verification/tb_icache_lce_cmd.sv
// testbench for the icache coherence engine command side, driven from a stimulus file
`timescale 1ns/10ps
`default_nettype none

module tb_icache_lce_cmd
  import lce_cfg_pkg::*;
  import lce_msg_pkg::*;
();

  localparam int num_sets_lp     = 64;
  localparam int num_cce_lp      = 2;
  localparam int reset_cycles_lp = 4;
  localparam int fields_lp       = 21;
  localparam int steps_lp        = 26;
  localparam int stall_set_lp    = 20;
  localparam int stall_len_lp    = 3;
  // two resets and sweeps, the stall, one cycle per stimulus line, plus margin
  localparam int timeout_lp =
    2 * (reset_cycles_lp + num_sets_lp + 2) + stall_len_lp + steps_lp + 50;

  logic        clk_i;
  logic        reset_i;
  node_id_t    lce_id;
  paddr_t      miss_addr;
  lce_cmd_s    lce_cmd;
  logic        lce_cmd_v;
  logic        lce_cmd_yumi;
  lce_resp_s   lce_resp;
  logic        lce_resp_v;
  logic        lce_resp_yumi;
  tag_pkt_s    tag_pkt;
  logic        tag_pkt_v;
  logic        tag_ready;
  stat_pkt_s   stat_pkt;
  logic        stat_pkt_v;
  logic        stat_ready;
  data_pkt_s   data_pkt;
  logic        data_pkt_v;
  logic        data_ready;
  logic        lce_ready;
  logic        set_tag_received;
  logic        set_tag_wakeup_received;
  logic        cce_data_received;
  logic        uncached_data_received;
  logic        cache_req_complete;
  logic [4:0]  strobes;
  logic [63:0] stim_mem [0:fields_lp*steps_lp-1];
  int          errors;
  int          checks;
  int          cycles = 0;

  assign strobes = {set_tag_received, set_tag_wakeup_received, cce_data_received,
                    uncached_data_received, cache_req_complete};

  icache_lce_cmd #(
    .num_sets_p(num_sets_lp),
    .num_cce_p (num_cce_lp)
  ) dut0 (
    .clk_i                    (clk_i),
    .reset_i                  (reset_i),
    .lce_id_i                 (lce_id),
    .miss_addr_i              (miss_addr),
    .lce_cmd_i                (lce_cmd),
    .lce_cmd_v_i              (lce_cmd_v),
    .lce_cmd_yumi_o           (lce_cmd_yumi),
    .lce_resp_o               (lce_resp),
    .lce_resp_v_o             (lce_resp_v),
    .lce_resp_yumi_i          (lce_resp_yumi),
    .tag_pkt_o                (tag_pkt),
    .tag_pkt_v_o              (tag_pkt_v),
    .tag_pkt_ready_i          (tag_ready),
    .stat_pkt_o               (stat_pkt),
    .stat_pkt_v_o             (stat_pkt_v),
    .stat_pkt_ready_i         (stat_ready),
    .data_pkt_o               (data_pkt),
    .data_pkt_v_o             (data_pkt_v),
    .data_pkt_ready_i         (data_ready),
    .lce_ready_o              (lce_ready),
    .set_tag_received_o       (set_tag_received),
    .set_tag_wakeup_received_o(set_tag_wakeup_received),
    .cce_data_received_o      (cce_data_received),
    .uncached_data_received_o (uncached_data_received),
    .cache_req_complete_o     (cache_req_complete)
  );

  bind icache_lce_cmd icache_lce_cmd_asserts asserts0 (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .lce_cmd_v_i     (lce_cmd_v_i),
    .lce_cmd_yumi_o  (lce_cmd_yumi_o),
    .lce_resp_v_o    (lce_resp_v_o),
    .lce_resp_yumi_i (lce_resp_yumi_i),
    .tag_pkt_v_o     (tag_pkt_v_o),
    .tag_pkt_ready_i (tag_pkt_ready_i),
    .stat_pkt_v_o    (stat_pkt_v_o),
    .stat_pkt_ready_i(stat_pkt_ready_i),
    .data_pkt_v_o    (data_pkt_v_o),
    .data_pkt_ready_i(data_pkt_ready_i)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_lp) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_lp);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %0h, expected %0h (cycle %0d)", name, got, exp, cycles);
    end
  endtask

  // caller is at a falling edge, or at time zero
  task automatic apply_reset();
    reset_i   = 1'b1;
    lce_cmd_v = 1'b0;
    repeat (reset_cycles_lp) @(negedge clk_i);
    reset_i = 1'b0;
  endtask

  // stall_set below zero runs the sweep with both readies held high
  task automatic run_sweep(input int stall_set, input int stall_len);
    int s;
    for (s = 0; s < num_sets_lp; s++) begin
      if (s == stall_set) begin
        stat_ready = 1'b0;
        repeat (stall_len) begin
          @(posedge clk_i);
          check_eq("tag_pkt_v_o", tag_pkt_v, 0);
          check_eq("stat_pkt_v_o", stat_pkt_v, 0);
          check_eq("tag_pkt_o.index", tag_pkt.index, s);
          check_eq("lce_ready_o", lce_ready, 0);
          @(negedge clk_i);
        end
        stat_ready = 1'b1;
      end
      @(posedge clk_i);
      check_eq("tag_pkt_v_o", tag_pkt_v, 1);
      check_eq("tag_pkt_o.opcode", tag_pkt.opcode, e_tag_set_clear);
      check_eq("tag_pkt_o.index", tag_pkt.index, s);
      check_eq("stat_pkt_v_o", stat_pkt_v, 1);
      check_eq("stat_pkt_o.index", stat_pkt.index, s);
      check_eq("stat_pkt_o.clear", stat_pkt.clear, 1);
      check_eq("lce_ready_o", lce_ready, 0);
      @(negedge clk_i);
    end
    @(posedge clk_i);
    check_eq("lce_ready_o", lce_ready, 1);
    check_eq("tag_pkt_v_o", tag_pkt_v, 0);
    @(negedge clk_i);
  endtask

  // e points at the first expected field of a stimulus line
  task automatic check_outputs(input int e);
    logic [63:0] resp_exp;
    resp_exp = stim_mem[e+1];
    check_eq("lce_cmd_yumi_o", lce_cmd_yumi, stim_mem[e]);
    check_eq("lce_resp_v_o", lce_resp_v, resp_exp[2]);
    if (resp_exp[2]) begin
      check_eq("lce_resp_o.msg_type", lce_resp.msg_type, resp_exp[1:0]);
      check_eq("lce_resp_o.src_id", lce_resp.src_id, lce_id);
      check_eq("lce_resp_o.dst_id", lce_resp.dst_id, lce_cmd.src_id);
      check_eq("lce_resp_o.addr", lce_resp.addr, lce_cmd.addr);
    end
    check_eq("tag_pkt_v_o", tag_pkt_v, stim_mem[e+2]);
    if (stim_mem[e+2][0]) begin
      check_eq("tag_pkt_o.opcode", tag_pkt.opcode, stim_mem[e+3]);
      check_eq("tag_pkt_o.index", tag_pkt.index, stim_mem[e+4]);
      check_eq("tag_pkt_o.state", tag_pkt.state, stim_mem[e+5]);
      check_eq("tag_pkt_o.way_id", tag_pkt.way_id, lce_cmd.way_id);
      if (stim_mem[e+3][1:0] == e_tag_set_tag) begin
        check_eq("tag_pkt_o.tag", tag_pkt.tag, stim_mem[e+6]);
      end
    end
    check_eq("stat_pkt_v_o", stat_pkt_v, stim_mem[e+7]);
    if (stim_mem[e+7][0]) begin
      check_eq("stat_pkt_o.index", stat_pkt.index, stim_mem[e+4]);
      check_eq("stat_pkt_o.clear", stat_pkt.clear, 1);
    end
    check_eq("data_pkt_v_o", data_pkt_v, stim_mem[e+8]);
    if (stim_mem[e+8][0]) begin
      check_eq("data_pkt_o.opcode", data_pkt.opcode, stim_mem[e+9]);
      check_eq("data_pkt_o.index", data_pkt.index, stim_mem[e+10]);
      check_eq("data_pkt_o.way_id", data_pkt.way_id, lce_cmd.way_id);
      check_eq("data_pkt_o.data", data_pkt.data, lce_cmd.data);
    end
    check_eq("event strobes", strobes, stim_mem[e+11]);
    check_eq("lce_ready_o", lce_ready, stim_mem[e+12]);
  endtask

  task automatic run_steps();
    int step;
    int b;
    logic [3:0] rdy;
    for (step = 0; step < steps_lp; step++) begin
      b                = step * fields_lp;
      lce_cmd_v        = stim_mem[b][0];
      lce_cmd.msg_type = lce_cmd_type_e'(stim_mem[b+1][3:0]);
      lce_cmd.src_id   = stim_mem[b+2][2:0];
      lce_cmd.way_id   = stim_mem[b+3][2:0];
      lce_cmd.state    = coh_state_e'(stim_mem[b+4][2:0]);
      lce_cmd.addr     = stim_mem[b+5][39:0];
      lce_cmd.data     = {lce_cmd.addr[31:0], ~lce_cmd.addr[31:0]};
      miss_addr        = stim_mem[b+6][39:0];
      rdy              = stim_mem[b+7][3:0];
      tag_ready        = rdy[3];
      stat_ready       = rdy[2];
      data_ready       = rdy[1];
      lce_resp_yumi    = rdy[0];
      @(posedge clk_i);
      check_outputs(b + 8);
      @(negedge clk_i);
    end
  endtask

  initial begin
    errors        = 0;
    checks        = 0;
    reset_i       = 1'b1;
    lce_id        = 3'h4;
    miss_addr     = '0;
    lce_cmd       = '0;
    lce_cmd_v     = 1'b0;
    lce_resp_yumi = 1'b0;
    tag_ready     = 1'b1;
    stat_ready    = 1'b1;
    data_ready    = 1'b1;
    $readmemh("verification/lce_cmd_stim.txt", stim_mem);
    if ($isunknown(stim_mem[fields_lp*steps_lp-1])) begin
      errors++;
      $display("the stimulus file could not be read completely");
    end
    apply_reset();
    run_sweep(-1, 0);
    apply_reset();
    run_sweep(stall_set_lp, stall_len_lp);
    run_steps();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
verilog/lce_cfg_pkg.sv
verilog/lce_msg_pkg.sv
verilog/lce_init_sweep.sv
verilog/lce_cmd_decode.sv
verilog/lce_mode_ctrl.sv
verilog/icache_lce_cmd.sv
verification/icache_lce_cmd_asserts.sv
verification/tb_icache_lce_cmd.sv

// File: Bender.yml
package:
  name: icache_lce_cmd

sources:
  - files:
      - verilog/lce_cfg_pkg.sv
      - verilog/lce_msg_pkg.sv
      - verilog/lce_init_sweep.sv
      - verilog/lce_cmd_decode.sv
      - verilog/lce_mode_ctrl.sv
      - verilog/icache_lce_cmd.sv
  - target: test
    files:
      - verification/icache_lce_cmd_asserts.sv
      - verification/tb_icache_lce_cmd.sv

// File: verification/lce_cmd_stim.txt
// v type src way state addr miss_addr ready(tag,stat,data,resp_yumi) then expected:
// yumi resp(4+type) tag_v op idx state tag stat_v data_v op idx strobes lce_ready
0 0 0 0 0 0000000000 5500000fc0 f 0 0 0 0 00 0 0000000 0 0 0 00 00 1
1 0 1 2 0 1234567a80 5500000fc0 b 0 0 0 0 2a 0 0000000 0 0 0 00 00 1
1 0 1 2 0 1234567a80 5500000fc0 f 1 0 1 0 2a 0 0000000 1 0 0 00 00 1
1 2 1 2 0 1234567a80 5500000fc0 d 0 0 0 0 00 0 0000000 0 0 0 00 00 1
1 2 1 2 0 1234567a80 5500000fc0 f 1 0 0 0 00 0 0000000 0 1 1 3f 03 1
1 3 1 5 1 1234567a80 5500000fc0 f 0 0 0 0 00 0 0000000 0 0 0 00 00 1
1 3 1 5 1 1234567a80 5500000fc0 f 0 0 0 0 00 0 0000000 0 0 0 00 00 1
0 0 0 0 0 0000000000 5500000fc0 f 0 0 0 0 00 0 0000000 0 0 0 00 00 1
1 1 1 0 0 1234567a80 5500000fc0 e 0 4 0 0 00 0 0000000 0 0 0 00 00 1
1 1 1 0 0 1234567a80 5500000fc0 f 1 4 0 0 00 0 0000000 0 0 0 00 00 1
1 1 2 0 0 abcdef0140 5500000fc0 f 1 4 0 0 00 0 0000000 0 0 0 00 00 1
1 3 1 5 1 1234567a80 5500000fc0 f 1 0 1 1 2a 1 1234567 0 0 0 00 10 1
1 4 2 3 2 abcdef0140 5500000fc0 f 1 0 1 1 05 2 abcdef0 0 0 0 00 09 1
1 6 1 6 3 000fedc9c0 5500000fc0 d 0 0 0 0 00 0 0000000 0 0 0 00 00 1
1 6 1 6 3 000fedc9c0 5500000fc0 7 0 0 0 0 00 0 0000000 0 0 0 00 00 1
1 6 1 6 3 000fedc9c0 5500000fc0 f 1 0 1 1 3f 3 000fedc 0 1 0 3f 15 1
1 5 2 5 1 1234567a80 5500000fc0 e 0 5 1 2 2a 0 0000000 0 0 0 00 00 1
1 5 2 5 1 1234567a80 5500000fc0 e 0 5 0 0 00 0 0000000 0 0 0 00 00 1
1 5 2 5 1 1234567a80 5500000fc0 e 0 5 0 0 00 0 0000000 0 0 0 00 00 1
1 5 2 5 1 1234567a80 5500000fc0 f 1 5 0 0 00 0 0000000 0 0 0 00 00 1
0 0 0 0 0 0000000000 5500000fc0 f 0 0 0 0 00 0 0000000 0 0 0 00 00 1
1 5 1 1 0 abcdef0140 5500000fc0 f 1 5 1 2 05 0 0000000 0 0 0 00 00 1
1 7 2 0 0 abcdef0140 5500000fc0 e 0 6 0 0 00 0 0000000 0 0 0 00 00 1
1 7 2 0 0 abcdef0140 5500000fc0 f 1 6 0 0 00 0 0000000 0 0 0 00 00 1
0 0 0 0 0 0000000000 5500000fc0 f 0 0 0 0 00 0 0000000 0 0 0 00 00 1
1 2 1 4 0 0000000000 0000000440 f 1 0 0 0 00 0 0000000 0 1 1 11 03 1
